//--- tb.f
verilog/soc_bus_pkg.sv
verilog/bus_addr_decode.sv
verilog/io_register_slaves.sv
verilog/simple_pic.sv
verilog/read_return_mux.sv
verilog/soc_bus_top.sv
dv/soc_bus_assertions.sv
dv/tb_soc_bus.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the SoC bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_soc_bus -f tb.f -o sim_tb_soc_bus
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb_soc_bus +verilator+error+limit+100 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Test failed" "$LOG"; then
  echo "simulation reported failure"
  exit 1
fi
if ! grep -q "Test passed" "$LOG"; then
  echo "simulation ended without a result"
  exit 1
fi

echo "simulation reported success"
exit 0

//--- dv/tb_soc_bus.sv
// CPU bus fabric testbench
// Directed tests for the POST code, GPIO, external memory, default
// responder and interrupt paths. Memory behind the fabric is a model
// with a random ack latency.

`timescale 1ns/100ps
`default_nettype none

module tb_soc_bus;

  localparam int CLK_PERIOD      = 4;
  localparam int RESET_CYCLES    = 8;
  localparam int MEM_WORDS       = 64;
  localparam int MAX_LATENCY     = 5;
  localparam int ACK_LIMIT       = 20;  // Cycles a master waits for ack
  localparam int MEM_WRITES      = 16;
  localparam int NUM_BUS_CYCLES  = 2 * MEM_WRITES + 12;
  localparam int WATCHDOG_CYCLES = NUM_BUS_CYCLES * (MAX_LATENCY + 4) + RESET_CYCLES + 200;

  logic                   clk = 1'b0;
  logic                   rst_lck;
  soc_bus_pkg::bus_req_t  cpu_req;
  logic                   inta;
  logic                   nmia;
  soc_bus_pkg::bus_rsp_t  cpu_rsp;
  logic                   intr;
  logic [7:0]             intv;
  soc_bus_pkg::bus_req_t  mem_req;
  soc_bus_pkg::bus_rsp_t  mem_rsp = '0;
  logic [7:0]             sw;
  logic [7:0]             leds;
  soc_bus_pkg::seg_pair_t post_seg;

  // Memory model state
  logic [15:0]            mem_array [MEM_WORDS];
  logic [5:0]             mem_idx;
  int                     mem_wait = -1;
  logic [31:0]            lat_state = 32'd47208;
  soc_bus_pkg::bus_req_t  mem_last_req = '0;  // Request seen at the last memory ack
  int                     stray_mem_cnt = 0;

  logic [31:0]            data_state = 32'd47208;
  int                     err_cnt = 0;
  int                     chk_cnt = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  soc_bus_top u_dut (
    .clk        (clk),
    .rst_lck    (rst_lck),
    .cpu_req_i  (cpu_req),
    .inta_i     (inta),
    .nmia_i     (nmia),
    .cpu_rsp_o  (cpu_rsp),
    .intr_o     (intr),
    .intv_i     (intv),
    .mem_req_o  (mem_req),
    .mem_rsp_i  (mem_rsp),
    .sw_i       (sw),
    .leds_o     (leds),
    .post_seg_o (post_seg)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Active high hex digit patterns in gfedcba order
  function automatic logic [6:0] hex_segments(input logic [3:0] nib);
    logic [6:0] s;
    case (nib)
      4'h0: s = 7'h3f;
      4'h1: s = 7'h06;
      4'h2: s = 7'h5b;
      4'h3: s = 7'h4f;
      4'h4: s = 7'h66;
      4'h5: s = 7'h6d;
      4'h6: s = 7'h7d;
      4'h7: s = 7'h07;
      4'h8: s = 7'h7f;
      4'h9: s = 7'h6f;
      4'ha: s = 7'h77;
      4'hb: s = 7'h7c;
      4'hc: s = 7'h39;
      4'hd: s = 7'h5e;
      4'he: s = 7'h79;
      4'hf: s = 7'h71;
    endcase
    return s;
  endfunction

  function automatic soc_bus_pkg::bus_addr_u io_addr(input logic [15:0] port);
    soc_bus_pkg::bus_addr_u a;
    a.io.is_io  = 1'b1;
    a.io.unused = 4'h0;
    a.io.port   = port[15:1];  // Byte port to port word
    return a;
  endfunction

  function automatic soc_bus_pkg::bus_addr_u mem_addr(input logic [18:0] word);
    soc_bus_pkg::bus_addr_u a;
    a.mem.is_io = 1'b0;
    a.mem.word  = word;
    return a;
  endfunction

  task automatic report_fail(input string msg);
    err_cnt++;
    $display("error t=%0t %s", $time, msg);
  endtask

  task automatic check_rsp(input string name, input soc_bus_pkg::bus_rsp_t got,
                           input logic [15:0] exp);
    chk_cnt++;
    if (got.dat !== exp) begin
      err_cnt++;
      $display("error t=%0t %s got=%h exp=%h", $time, name, got.dat, exp);
    end
  endtask

  task automatic check_seg(input string name, input soc_bus_pkg::seg_pair_t got,
                           input soc_bus_pkg::seg_pair_t exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error t=%0t %s got=%h/%h exp=%h/%h", $time, name, got.hi, got.lo,
               exp.hi, exp.lo);
    end
  endtask

  task automatic check_req(input string name, input soc_bus_pkg::bus_req_t got,
                           input soc_bus_pkg::bus_req_t exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error t=%0t %s got=%h exp=%h", $time, name, got, exp);
    end
  endtask

  task automatic check_bits(input string name, input logic [7:0] got, input logic [7:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error t=%0t %s got=%h exp=%h", $time, name, got, exp);
    end
  endtask

  // One Wishbone classic cycle with the request held until ack
  task automatic bus_cycle(input logic we, input soc_bus_pkg::bus_addr_u addr,
                           input logic [15:0] dat, input logic [1:0] sel,
                           input logic int_ack, input logic nmi_ack,
                           output soc_bus_pkg::bus_rsp_t rsp);
    int waited;
    waited = 0;
    rsp = '0;
    @(posedge clk);
    #0.5;
    cpu_req.dat  = dat;
    cpu_req.addr = addr;
    cpu_req.sel  = sel;
    cpu_req.we   = we;
    cpu_req.cyc  = 1'b1;
    cpu_req.stb  = 1'b1;
    inta = int_ack;
    nmia = nmi_ack;
    @(negedge clk);
    while (!cpu_rsp.ack && waited < ACK_LIMIT) begin
      waited++;
      @(negedge clk);
    end
    if (cpu_rsp.ack) begin
      rsp = cpu_rsp;
    end else begin
      report_fail("bus cycle got no ack");
    end
    @(posedge clk);
    #0.5;
    cpu_req = '0;  // Drop stb the cycle after ack
    inta = 1'b0;
    nmia = 1'b0;
  endtask

  // External RAM model that acks after 0 to MAX_LATENCY extra cycles
  always @(posedge clk) begin
    #1;
    if (mem_rsp.ack) begin
      mem_rsp.ack = 1'b0;  // Single cycle pulse
    end else if (mem_req.stb) begin
      if (cpu_req.addr.mem.is_io || inta || nmia) begin
        stray_mem_cnt++;
      end
      if (mem_wait < 0) begin
        lat_state = xorshift32(lat_state);
        mem_wait = int'(lat_state % (MAX_LATENCY + 1));
      end
      if (mem_wait == 0) begin
        mem_idx = mem_req.addr.mem.word[5:0];
        if (mem_req.we && mem_req.sel[0]) begin
          mem_array[mem_idx][7:0] = mem_req.dat[7:0];
        end
        if (mem_req.we && mem_req.sel[1]) begin
          mem_array[mem_idx][15:8] = mem_req.dat[15:8];
        end
        mem_rsp.dat  = mem_array[mem_idx];
        mem_rsp.ack  = 1'b1;
        mem_last_req = mem_req;
        mem_wait     = -1;
      end else begin
        mem_wait--;
      end
    end
  end

  task automatic reset_state_test();
    soc_bus_pkg::seg_pair_t exp_seg;
    exp_seg.hi = ~hex_segments(4'h0);
    exp_seg.lo = ~hex_segments(4'h0);
    @(negedge clk);
    check_bits("cpu_rsp_o.ack", {7'b0, cpu_rsp.ack}, 8'h00);
    check_bits("mem_req_o.stb", {7'b0, mem_req.stb}, 8'h00);
    check_bits("mem_req_o.cyc", {7'b0, mem_req.cyc}, 8'h00);
    check_bits("intr_o", {7'b0, intr}, 8'h00);
    check_bits("leds_o", leds, 8'h00);
    check_seg("post_seg_o", post_seg, exp_seg);
  endtask

  task automatic post_code_test();
    soc_bus_pkg::bus_rsp_t  rsp;
    soc_bus_pkg::seg_pair_t exp_seg;
    bus_cycle(1'b1, io_addr(16'h0080), 16'h003a, 2'b11, 1'b0, 1'b0, rsp);
    bus_cycle(1'b0, io_addr(16'h0080), 16'h0000, 2'b11, 1'b0, 1'b0, rsp);
    check_rsp("cpu_rsp_o.dat", rsp, 16'h003a);
    exp_seg.hi = ~hex_segments(4'h3);
    exp_seg.lo = ~hex_segments(4'ha);
    @(negedge clk);
    check_seg("post_seg_o", post_seg, exp_seg);
  endtask

  task automatic gpio_test();
    soc_bus_pkg::bus_rsp_t rsp;
    bus_cycle(1'b0, io_addr(16'hf100), 16'h0000, 2'b11, 1'b0, 1'b0, rsp);
    check_rsp("cpu_rsp_o.dat", rsp, {8'h00, sw});
    bus_cycle(1'b1, io_addr(16'hf100), 16'h00c5, 2'b11, 1'b0, 1'b0, rsp);
    @(negedge clk);
    check_bits("leds_o", leds, 8'hc5);
    bus_cycle(1'b0, io_addr(16'hf102), 16'h0000, 2'b11, 1'b0, 1'b0, rsp);
    check_rsp("cpu_rsp_o.dat", rsp, 16'h00c5);
    // High byte only has no LEDs
    bus_cycle(1'b1, io_addr(16'hf100), 16'h3300, 2'b10, 1'b0, 1'b0, rsp);
    @(negedge clk);
    check_bits("leds_o", leds, 8'hc5);
  endtask

  task automatic ext_mem_test();
    soc_bus_pkg::bus_rsp_t rsp;
    soc_bus_pkg::bus_req_t exp_req;
    logic [15:0]           shadow [MEM_WORDS];
    logic                  written [MEM_WORDS];
    logic [5:0]            idx;
    logic [15:0]           dat;
    logic [1:0]            sel;
    for (int i = 0; i < MEM_WORDS; i++) begin
      written[i] = 1'b0;
    end
    for (int i = 0; i < MEM_WRITES; i++) begin
      data_state = xorshift32(data_state);
      idx = data_state[5:0];
      dat = data_state[21:6];
      sel = (data_state[23:22] == 2'b00 || !written[idx]) ? 2'b11 : data_state[23:22];
      exp_req      = '0;
      exp_req.dat  = dat;
      exp_req.addr = mem_addr({13'h0, idx});
      exp_req.sel  = sel;
      exp_req.we   = 1'b1;
      exp_req.cyc  = 1'b1;
      exp_req.stb  = 1'b1;
      bus_cycle(1'b1, exp_req.addr, dat, sel, 1'b0, 1'b0, rsp);
      check_req("mem_req_o", mem_last_req, exp_req);
      if (sel[0]) begin
        shadow[idx][7:0] = dat[7:0];
      end
      if (sel[1]) begin
        shadow[idx][15:8] = dat[15:8];
      end
      written[idx] = 1'b1;
    end
    for (int i = 0; i < MEM_WORDS; i++) begin
      if (written[i]) begin
        bus_cycle(1'b0, mem_addr(19'(i)), 16'h0000, 2'b11, 1'b0, 1'b0, rsp);
        check_rsp("cpu_rsp_o.dat", rsp, shadow[i]);
      end
    end
  endtask

  task automatic default_port_test();
    soc_bus_pkg::bus_rsp_t rsp;
    int                    stray_before;
    stray_before = stray_mem_cnt;
    bus_cycle(1'b0, io_addr(16'h0300), 16'h0000, 2'b11, 1'b0, 1'b0, rsp);
    check_rsp("cpu_rsp_o.dat", rsp, 16'h0000);
    if (stray_mem_cnt != stray_before) begin
      report_fail("unmapped port cycle reached the memory port");
    end
  endtask

  task automatic interrupt_test();
    soc_bus_pkg::bus_rsp_t rsp;
    int                    stray_before;
    stray_before = stray_mem_cnt;
    @(posedge clk);
    #0.5;
    intv = 8'b0010_1000;  // Lines 5 and 3
    @(posedge clk);
    #0.5;
    intv = 8'h00;
    @(negedge clk);
    check_bits("intr_o", {7'b0, intr}, 8'h01);
    bus_cycle(1'b0, mem_addr(19'h0), 16'h0000, 2'b11, 1'b1, 1'b0, rsp);
    check_rsp("cpu_rsp_o.dat", rsp, 16'h000b);
    bus_cycle(1'b0, mem_addr(19'h0), 16'h0000, 2'b11, 1'b1, 1'b0, rsp);
    check_rsp("cpu_rsp_o.dat", rsp, 16'h000d);
    @(negedge clk);
    check_bits("intr_o", {7'b0, intr}, 8'h00);
    bus_cycle(1'b0, mem_addr(19'h0), 16'h0000, 2'b11, 1'b0, 1'b1, rsp);
    check_rsp("cpu_rsp_o.dat", rsp, 16'h0002);
    if (stray_mem_cnt != stray_before) begin
      report_fail("acknowledge cycle reached the memory port");
    end
  endtask

  initial begin
    cpu_req = '0;
    inta    = 1'b0;
    nmia    = 1'b0;
    intv    = 8'hff;  // Edges during reset must not leave a pending line
    sw      = 8'h96;
    rst_lck = 1'b0;
    repeat (RESET_CYCLES / 2) @(posedge clk);
    #0.5;
    intv = 8'h00;
    repeat (RESET_CYCLES / 2) @(posedge clk);
    #0.5;
    rst_lck = 1'b1;
    reset_state_test();
    post_code_test();
    gpio_test();
    ext_mem_test();
    default_port_test();
    interrupt_test();
    repeat (4) @(posedge clk);
    $display("checks %0d errors %0d assertion failures %0d", chk_cnt, err_cnt,
             u_dut.u_assertions.fail_cnt);
    if (err_cnt == 0 && u_dut.u_assertions.fail_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Worst case is every bus cycle at full memory latency
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/soc_bus_assertions.sv
// Bus protocol assertions
// Bound to the fabric top level. Checks the CPU handshake, the one
// cycle ack latency of internal targets and the interrupt line under
// reset.

`timescale 1ns/100ps
`default_nettype none

module soc_bus_assertions (
  input logic                     clk,
  input logic                     rst_lck,
  input soc_bus_pkg::bus_req_t    cpu_req_i,
  input soc_bus_pkg::bus_rsp_t    cpu_rsp_o,
  input soc_bus_pkg::bus_target_e target_i,
  input logic                     intr_o
);

  int fail_ack  = 0;
  int fail_hold = 0;
  int fail_one  = 0;
  int fail_rst  = 0;
  int fail_cnt;

  assign fail_cnt = fail_ack + fail_hold + fail_one + fail_rst;

  ack_needs_stb: assert property (@(posedge clk) disable iff (!rst_lck)
      cpu_rsp_o.ack |-> (cpu_req_i.cyc && cpu_req_i.stb))
    else begin
      $error("ack without an active strobe");
      fail_ack++;
    end

  req_held: assert property (@(posedge clk) disable iff (!rst_lck)
      (cpu_req_i.cyc && cpu_req_i.stb && !cpu_rsp_o.ack) |=> $stable(cpu_req_i))
    else begin
      $error("request changed before ack");
      fail_hold++;
    end

  // Internal slaves and vectors answer in the cycle after the strobe
  int_ack_next: assert property (@(posedge clk) disable iff (!rst_lck)
      (cpu_req_i.cyc && cpu_req_i.stb && !cpu_rsp_o.ack &&
       target_i != soc_bus_pkg::TGT_EXT_MEM) |=> cpu_rsp_o.ack)
    else begin
      $error("internal ack not one cycle after the strobe");
      fail_one++;
    end

  intr_in_reset: assert property (@(posedge clk) !rst_lck |=> !intr_o)
    else begin
      $error("intr_o high during reset");
      fail_rst++;
    end

endmodule

bind soc_bus_top soc_bus_assertions u_assertions (
  .clk       (clk),
  .rst_lck   (rst_lck),
  .cpu_req_i (cpu_req_i),
  .cpu_rsp_o (cpu_rsp_o),
  .target_i  (target),
  .intr_o    (intr_o)
);

`default_nettype wire

//--- verilog/soc_bus_top.sv
// CPU bus fabric top
// Connects the address decoder, the I/O register slaves, the interrupt
// controller and the read return merge between the CPU master port and
// the external memory port

`timescale 1ns/100ps
`default_nettype none

module soc_bus_top (
  input  logic                            clk,
  input  logic                            rst_lck,
  input  soc_bus_pkg::bus_req_t           cpu_req_i,
  input  logic                            inta_i,
  input  logic                            nmia_i,
  output soc_bus_pkg::bus_rsp_t           cpu_rsp_o,
  output logic                            intr_o,
  input  logic [soc_bus_pkg::NUM_IRQ-1:0] intv_i,
  output soc_bus_pkg::bus_req_t           mem_req_o,
  input  soc_bus_pkg::bus_rsp_t           mem_rsp_i,
  input  logic [7:0]                      sw_i,
  output logic [7:0]                      leds_o,
  output soc_bus_pkg::seg_pair_t          post_seg_o
);

  soc_bus_pkg::bus_target_e target;
  soc_bus_pkg::bus_rsp_t    io_rsp;
  logic                     io_stb;
  logic                     vec_stb;
  logic [2:0]               iid;

  bus_addr_decode u_decode (
    .cpu_req_i (cpu_req_i),
    .inta_i    (inta_i),
    .nmia_i    (nmia_i),
    .target_o  (target),
    .io_stb_o  (io_stb),
    .vec_stb_o (vec_stb),
    .mem_req_o (mem_req_o)
  );

  io_register_slaves u_io (
    .clk        (clk),
    .rst_lck    (rst_lck),
    .cpu_req_i  (cpu_req_i),
    .target_i   (target),
    .io_stb_i   (io_stb),
    .sw_i       (sw_i),
    .io_rsp_o   (io_rsp),
    .leds_o     (leds_o),
    .post_seg_o (post_seg_o)
  );

  simple_pic u_pic (
    .clk     (clk),
    .rst_lck (rst_lck),
    .intv_i  (intv_i),
    .inta_i  (inta_i),
    .intr_o  (intr_o),
    .iid_o   (iid)
  );

  read_return_mux u_ret (
    .clk       (clk),
    .rst_lck   (rst_lck),
    .target_i  (target),
    .vec_stb_i (vec_stb),
    .iid_i     (iid),
    .io_rsp_i  (io_rsp),
    .mem_rsp_i (mem_rsp_i),
    .cpu_rsp_o (cpu_rsp_o)
  );

endmodule

`default_nettype wire

//--- verilog/read_return_mux.sv
// Read return merge
// Builds the interrupt and NMI acknowledge vectors with a registered
// ack and hands the CPU the response of the decoded target

`timescale 1ns/100ps
`default_nettype none

module read_return_mux (
  input  logic                     clk,
  input  logic                     rst_lck,
  input  soc_bus_pkg::bus_target_e target_i,
  input  logic                     vec_stb_i,
  input  logic [2:0]               iid_i,
  input  soc_bus_pkg::bus_rsp_t    io_rsp_i,
  input  soc_bus_pkg::bus_rsp_t    mem_rsp_i,
  output soc_bus_pkg::bus_rsp_t    cpu_rsp_o
);

  logic        vec_ack_q;
  logic [15:0] vec_dat_q;
  logic        vec_take;

  assign vec_take = vec_stb_i & ~vec_ack_q;

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      vec_ack_q <= 1'b0;
    end else begin
      vec_ack_q <= vec_take;
    end
  end

  // iid sampled in the same cycle the PIC sees the inta edge
  always_ff @(posedge clk) begin
    if (vec_take) begin
      if (target_i == soc_bus_pkg::TGT_NMI_VEC) begin
        vec_dat_q <= soc_bus_pkg::NMI_VEC;
      end else begin
        vec_dat_q <= soc_bus_pkg::INT_VEC_BASE + {13'b0, iid_i};
      end
    end
  end

  always_comb begin
    case (target_i)
      soc_bus_pkg::TGT_EXT_MEM: cpu_rsp_o = mem_rsp_i;  // Same-cycle pass
      soc_bus_pkg::TGT_INT_VEC,
      soc_bus_pkg::TGT_NMI_VEC: begin
        cpu_rsp_o.dat = vec_dat_q;
        cpu_rsp_o.ack = vec_ack_q;
      end
      default:                  cpu_rsp_o = io_rsp_i;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/simple_pic.sv
// Simple interrupt controller
// Captures rising edges of eight request lines, raises intr while any
// line is pending, and reports the lowest pending line as iid. The
// acknowledge edge clears that line.

`timescale 1ns/100ps
`default_nettype none

module simple_pic (
  input  logic                             clk,
  input  logic                             rst_lck,
  input  logic [soc_bus_pkg::NUM_IRQ-1:0]  intv_i,
  input  logic                             inta_i,
  output logic                             intr_o,
  output logic [2:0]                       iid_o
);

  logic [soc_bus_pkg::NUM_IRQ-1:0] intv_q;
  logic [soc_bus_pkg::NUM_IRQ-1:0] pending_q;
  logic [soc_bus_pkg::NUM_IRQ-1:0] intv_rise;
  logic [soc_bus_pkg::NUM_IRQ-1:0] clr_mask;
  logic                            inta_q;
  logic                            inta_rise;

  assign intv_rise = intv_i & ~intv_q;
  assign inta_rise = inta_i & ~inta_q;
  assign clr_mask  = inta_rise ? ({{(soc_bus_pkg::NUM_IRQ-1){1'b0}}, 1'b1} << iid_o) : '0;

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      intv_q    <= '0;
      inta_q    <= 1'b0;
      pending_q <= '0;
    end else begin
      intv_q    <= intv_i;
      inta_q    <= inta_i;
      pending_q <= (pending_q & ~clr_mask) | intv_rise;  // New edge wins
    end
  end

  // Lowest line has the highest priority
  always_comb begin
    iid_o = 3'd0;
    for (int i = soc_bus_pkg::NUM_IRQ - 1; i >= 0; i--) begin
      if (pending_q[i]) begin
        iid_o = i[2:0];
      end
    end
  end

  assign intr_o = |pending_q;

endmodule

`default_nettype wire

//--- verilog/io_register_slaves.sv
// I/O register slaves
// POST code register with two seven-segment digits, GPIO switches and
// LEDs, and the default responder for unmapped ports. All three answer
// with a registered ack one cycle after the strobe.

`timescale 1ns/100ps
`default_nettype none

module io_register_slaves (
  input  logic                     clk,
  input  logic                     rst_lck,
  input  soc_bus_pkg::bus_req_t    cpu_req_i,
  input  soc_bus_pkg::bus_target_e target_i,
  input  logic                     io_stb_i,
  input  logic [7:0]               sw_i,
  output soc_bus_pkg::bus_rsp_t    io_rsp_o,
  output logic [7:0]               leds_o,
  output soc_bus_pkg::seg_pair_t   post_seg_o
);

  logic        ack_q;
  logic [15:0] rd_dat_q;
  logic [7:0]  post_q;
  logic [7:0]  leds_q;
  logic        access;
  logic        wr_en;
  logic        gpio_word1;
  logic [15:0] rd_dat;

  assign access     = io_stb_i & ~ack_q;  // First cycle of the strobe only
  assign wr_en      = access & cpu_req_i.we;
  assign gpio_word1 = cpu_req_i.addr.io.port[0];

  always_comb begin
    case (target_i)
      soc_bus_pkg::TGT_POST: rd_dat = {8'h00, post_q};
      soc_bus_pkg::TGT_GPIO: rd_dat = gpio_word1 ? {8'h00, leds_q} : {8'h00, sw_i};
      default:               rd_dat = soc_bus_pkg::DEFAULT_RD_DATA;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      ack_q  <= 1'b0;
      post_q <= 8'h00;
      leds_q <= 8'h00;
    end else begin
      ack_q <= access;
      if (wr_en && cpu_req_i.sel[0]) begin
        if (target_i == soc_bus_pkg::TGT_POST) begin
          post_q <= cpu_req_i.dat[7:0];
        end
        if (target_i == soc_bus_pkg::TGT_GPIO && !gpio_word1) begin
          leds_q <= cpu_req_i.dat[7:0];  // High byte has no LEDs
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      rd_dat_q <= rd_dat;
    end
  end

  assign io_rsp_o.dat = rd_dat_q;
  assign io_rsp_o.ack = ack_q;
  assign leds_o       = leds_q;

  // Digits are wired active low
  assign post_seg_o.hi = ~soc_bus_pkg::HEX_SEG_TABLE[post_q[7:4]];
  assign post_seg_o.lo = ~soc_bus_pkg::HEX_SEG_TABLE[post_q[3:0]];

endmodule

`default_nettype wire

//--- verilog/bus_addr_decode.sv
// Bus address decoder
// Picks one target per CPU cycle: vector cycles first, then memory or
// I/O by the address io flag, then the masked I/O port map. Gates the
// strobe towards external memory, the I/O slaves and the vector source.

`timescale 1ns/100ps
`default_nettype none

module bus_addr_decode (
  input  soc_bus_pkg::bus_req_t    cpu_req_i,
  input  logic                     inta_i,
  input  logic                     nmia_i,
  output soc_bus_pkg::bus_target_e target_o,
  output logic                     io_stb_o,
  output logic                     vec_stb_o,
  output soc_bus_pkg::bus_req_t    mem_req_o
);

  logic        bus_stb;
  logic [14:0] port;
  logic        post_hit;
  logic        gpio_hit;
  logic        mem_sel;

  assign bus_stb = cpu_req_i.cyc & cpu_req_i.stb;
  assign port    = cpu_req_i.addr.io.port;

  assign post_hit = (port & soc_bus_pkg::POST_PORT_MASK) == soc_bus_pkg::POST_PORT_ADDR;
  assign gpio_hit = (port & soc_bus_pkg::GPIO_PORT_MASK) == soc_bus_pkg::GPIO_PORT_ADDR;

  always_comb begin
    if (nmia_i) begin
      target_o = soc_bus_pkg::TGT_NMI_VEC;
    end else if (inta_i) begin
      target_o = soc_bus_pkg::TGT_INT_VEC;
    end else if (!cpu_req_i.addr.mem.is_io) begin
      target_o = soc_bus_pkg::TGT_EXT_MEM;  // whole memory space is base RAM
    end else if (post_hit) begin
      target_o = soc_bus_pkg::TGT_POST;
    end else if (gpio_hit) begin
      target_o = soc_bus_pkg::TGT_GPIO;
    end else begin
      target_o = soc_bus_pkg::TGT_DEFAULT;
    end
  end

  assign mem_sel = target_o == soc_bus_pkg::TGT_EXT_MEM;

  assign io_stb_o  = bus_stb & (target_o inside {soc_bus_pkg::TGT_POST,
                                                 soc_bus_pkg::TGT_GPIO,
                                                 soc_bus_pkg::TGT_DEFAULT});
  assign vec_stb_o = bus_stb & (target_o inside {soc_bus_pkg::TGT_INT_VEC,
                                                 soc_bus_pkg::TGT_NMI_VEC});

  // Memory port sees the request only for its own cycles
  always_comb begin
    mem_req_o     = cpu_req_i;
    mem_req_o.cyc = cpu_req_i.cyc & mem_sel;
    mem_req_o.stb = bus_stb & mem_sel;
  end

endmodule

`default_nettype wire

//--- verilog/soc_bus_pkg.sv
// SoC bus package
// Shared bus structs, the address word union, the target encoding,
// the I/O port map and the seven-segment digit table for the CPU-side
// Wishbone fabric

`default_nettype none

package soc_bus_pkg;

  localparam int NUM_IRQ = 8;

  // Memory view of the 20-bit bus address
  typedef struct packed {
    logic        is_io;
    logic [18:0] word;
  } mem_addr_t;

  // I/O view, port word is port address bits 15:1
  typedef struct packed {
    logic        is_io;
    logic [3:0]  unused;
    logic [14:0] port;
  } io_addr_t;

  typedef union packed {
    mem_addr_t mem;
    io_addr_t  io;
  } bus_addr_u;

  typedef struct packed {
    logic [15:0] dat;
    bus_addr_u   addr;
    logic [1:0]  sel;
    logic        we;
    logic        cyc;
    logic        stb;
  } bus_req_t;

  typedef struct packed {
    logic [15:0] dat;
    logic        ack;
  } bus_rsp_t;

  typedef enum logic [2:0] {
    TGT_EXT_MEM,
    TGT_POST,
    TGT_GPIO,
    TGT_DEFAULT,
    TGT_INT_VEC,
    TGT_NMI_VEC
  } bus_target_e;

  // Active low digits
  typedef struct packed {
    logic [6:0] hi;
    logic [6:0] lo;
  } seg_pair_t;

  // Port word map, matched as (port & MASK) == ADDR
  localparam logic [14:0] POST_PORT_ADDR = 15'h0040; // 0x80-0x81
  localparam logic [14:0] POST_PORT_MASK = 15'h7fff;
  localparam logic [14:0] GPIO_PORT_ADDR = 15'h7880; // 0xf100-0xf103
  localparam logic [14:0] GPIO_PORT_MASK = 15'h7ffe;

  localparam logic [15:0] INT_VEC_BASE    = 16'h0008;
  localparam logic [15:0] NMI_VEC         = 16'h0002;
  localparam logic [15:0] DEFAULT_RD_DATA = 16'h0000;

  // gfedcba, active high, entry 0 in the low bits
  localparam logic [15:0][6:0] HEX_SEG_TABLE = {
    7'h71, 7'h79, 7'h5e, 7'h39,  // F E d C
    7'h7c, 7'h77, 7'h6f, 7'h7f,  // b A 9 8
    7'h07, 7'h7d, 7'h6d, 7'h66,  // 7 6 5 4
    7'h4f, 7'h5b, 7'h06, 7'h3f   // 3 2 1 0
  };

endpackage

`default_nettype wire
